//--- memtest_pkg.sv
`default_nettype none

package memtest_pkg;

    ////////////////////
    // memory geometry
    ////////////////////

    localparam int C_addr_w = 6;                 // 64 words under test
    localparam int C_words  = 1 << C_addr_w;

    typedef logic [15:0]         word_t;         // one data word
    typedef logic [C_addr_w-1:0] addr_t;         // word address
    typedef logic [31:0]         count_t;        // pass/fail/seconds counters
    typedef logic [15:0]         bcd4_t;         // four bcd digits of minutes

    localparam addr_t C_addr_last = addr_t'(C_words - 1);  // end of a sweep

    ////////////////////
    // timebase
    ////////////////////

    // one second is only a few clocks here so minutes roll in sim
    localparam int C_ticks_per_sec = 10;
    localparam int C_secs_per_min  = 60;

    localparam int C_tick_w = $clog2(C_ticks_per_sec);
    typedef logic [C_tick_w-1:0] tick_t;
    localparam tick_t C_tick_last = tick_t'(C_ticks_per_sec - 1);

    localparam int C_sec_w = $clog2(C_secs_per_min);
    typedef logic [C_sec_w-1:0] sec_t;
    localparam sec_t C_sec_last = sec_t'(C_secs_per_min - 1);  // 59

    ////////////////////
    // pattern lfsr
    ////////////////////

    localparam word_t C_lfsr_taps = 16'hB400;    // x^16+x^14+x^13+x^11+1
    localparam word_t C_lfsr_seed = 16'hACE1;    // base seed, per-pass xor on top

endpackage

`default_nettype wire

//--- pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none

// galois lfsr, one step per command
module pattern_gen import memtest_pkg::*; (
    input  wire        clk_gui,
    input  wire        timer_reset,
    input  wire        load,         // restart from seed
    input  wire word_t seed,
    input  wire        step,         // advance one position
    output word_t      value
);

    word_t lfsr_next;

    // shift right, fold taps back in when a one falls out
    always_comb begin
        lfsr_next = {1'b0, value[15:1]};
        if (value[0]) begin
            lfsr_next = lfsr_next ^ C_lfsr_taps;
        end
    end

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            value <= C_lfsr_seed;            // any nonzero start
        end else if (load) begin
            value <= seed;                   // load wins over step
        end else if (step) begin
            value <= lfsr_next;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // an all-zero state would lock up the sequence for the whole pass
    a_no_zero_after_load: assert property (
        @(posedge clk_gui) disable iff (timer_reset)
        load |=> (value != '0)
    );

endmodule

`default_nettype wire

//--- apb_sram.sv
`timescale 1ns/1ps
`default_nettype none

// apb slave word ram, reads take one wait state
module apb_sram import memtest_pkg::*; (
    input  wire        clk_gui,
    input  wire        timer_reset,
    input  wire        psel,
    input  wire        penable,
    input  wire        pwrite,
    input  wire addr_t paddr,
    input  wire word_t pwdata,
    input  wire word_t stuck_mask,   // bits forced high on read, fake bad chip
    output word_t      prdata,
    output logic       pready
);

    word_t mem [C_words];            // storage array
    logic  access;                   // apb access phase
    logic  rd_wait;                  // first read access cycle done
    logic  rd_first;                 // first access cycle of a read

    assign access   = psel & penable;
    assign rd_first = access & ~pwrite & ~rd_wait;

    // writes complete at once, reads on the second access cycle
    assign pready = access & (pwrite | rd_wait);

    ////////////////////
    // array
    ////////////////////

    always_ff @(posedge clk_gui) begin
        if (access && pwrite) begin
            mem[paddr] <= pwdata;
        end
    end

    // data fetched on the first access cycle, valid with pready
    always_ff @(posedge clk_gui) begin
        if (rd_first) begin
            prdata <= mem[paddr] | stuck_mask;   // stuck-high fault injection
        end
    end

    ////////////////////
    // wait state
    ////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            rd_wait <= 1'b0;
        end else begin
            rd_wait <= rd_first;     // high for exactly one cycle
        end
    end

    // master must not drop the transfer before we answer
    a_psel_held: assert property (
        @(posedge clk_gui) disable iff (timer_reset)
        (psel && !pready) |=> psel
    );

endmodule

`default_nettype wire

//--- elapsed_timer.sv
`timescale 1ns/1ps
`default_nettype none

// elapsed time since reset release, binary secs and bcd mins
module elapsed_timer import memtest_pkg::*; (
    input  wire clk_gui,
    input  wire timer_reset,
    output count_t secs,             // binary seconds
    output bcd4_t  mins              // 0000..9999 bcd
);

    tick_t tick_cnt;                 // clocks within the current second
    sec_t  sec_in_min;               // seconds within the current minute
    logic  sec_tick;
    logic  min_tick;
    bcd4_t mins_inc;                 // mins plus one, bcd
    logic  carry;                    // ripple between digits

    assign sec_tick = (tick_cnt == C_tick_last);
    assign min_tick = sec_tick && (sec_in_min == C_sec_last);

    ////////////////////
    // second divider
    ////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            tick_cnt <= '0;
            secs     <= '0;
        end else if (sec_tick) begin
            tick_cnt <= '0;
            secs     <= secs + 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    ////////////////////
    // minutes
    ////////////////////

    // bcd increment, 9 rolls to 0 and carries up, 9999 wraps
    always_comb begin
        carry    = 1'b1;
        mins_inc = mins;
        for (int i = 0; i < 4; i++) begin
            if (carry) begin
                if (mins[4*i +: 4] == 4'd9) begin
                    mins_inc[4*i +: 4] = 4'd0;           // keep carrying
                end else begin
                    mins_inc[4*i +: 4] = mins[4*i +: 4] + 4'd1;
                    carry = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            sec_in_min <= '0;
            mins       <= '0;
        end else if (sec_tick) begin
            sec_in_min <= min_tick ? '0 : sec_in_min + 1'b1;
            if (min_tick) begin
                mins <= mins_inc;
            end
        end
    end

    // no digit may ever leave the bcd range
    a_bcd_digits: assert property (
        @(posedge clk_gui) disable iff (timer_reset)
        (mins[3:0] <= 4'd9) && (mins[7:4] <= 4'd9) &&
        (mins[11:8] <= 4'd9) && (mins[15:12] <= 4'd9)
    );

endmodule

`default_nettype wire

//--- mem_tester.sv
`timescale 1ns/1ps
`default_nettype none

// apb master, write sweep then read-back sweep, one verdict per pass
module mem_tester import memtest_pkg::*; (
    input  wire        clk_gui,
    input  wire        timer_reset,
    // apb master
    output logic       psel,
    output logic       penable,
    output logic       pwrite,
    output addr_t      paddr,
    output word_t      pwdata,
    input  wire word_t prdata,
    input  wire        pready,
    // results
    output count_t     passcount,
    output count_t     failcount,
    output word_t      err_words,    // bad words in the last pass
    output logic       pass_done     // one-cycle pulse per pass
);

    typedef enum logic [2:0] {
        st_load,                     // seed the generator for writes
        st_wr_setup,
        st_wr_access,
        st_reload,                   // same seed again for compare
        st_rd_setup,
        st_rd_access,
        st_verdict
    } state_t;

    state_t state;
    addr_t  addr;                    // sweep position
    word_t  err_run;                 // mismatches so far this pass
    count_t pass_idx;                // index of the current pass
    word_t  pass_seed;
    word_t  pat_value;
    logic   pat_load;
    logic   pat_step;
    logic   mismatch;

    ////////////////////
    // pattern source
    ////////////////////

    // seed moves with pass index, bit 0 forced so never zero
    assign pass_idx  = passcount + failcount;
    assign pass_seed = (C_lfsr_seed ^ pass_idx[15:0]) | 16'h0001;

    assign pat_load = (state == st_load) || (state == st_reload);
    assign pat_step = pready && ((state == st_wr_access) || (state == st_rd_access));

    pattern_gen i_pattern_gen (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .load        (pat_load),
        .seed        (pass_seed),
        .step        (pat_step),
        .value       (pat_value)
    );

    assign mismatch = (prdata != pat_value);

    ////////////////////
    // apb drive
    ////////////////////

    assign paddr  = addr;
    assign pwdata = pat_value;       // generator only steps on pready

    always_comb begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        case (state)
            st_wr_setup: begin
                psel   = 1'b1;
                pwrite = 1'b1;
            end
            st_wr_access: begin
                psel    = 1'b1;
                penable = 1'b1;
                pwrite  = 1'b1;
            end
            st_rd_setup:  psel = 1'b1;
            st_rd_access: begin
                psel    = 1'b1;
                penable = 1'b1;
            end
            default: ;               // idle between sweeps
        endcase
    end

    ////////////////////
    // sequencer
    ////////////////////

    always_ff @(posedge clk_gui) begin
        pass_done <= 1'b0;
        if (timer_reset) begin
            state     <= st_load;
            addr      <= '0;
            err_run   <= '0;
            passcount <= '0;
            failcount <= '0;
            err_words <= '0;
        end else begin
            case (state)
                st_load: begin
                    addr    <= '0;
                    err_run <= '0;
                    state   <= st_wr_setup;
                end
                st_wr_setup: state <= st_wr_access;
                st_wr_access: if (pready) begin
                    if (addr == C_addr_last) begin
                        state <= st_reload;
                    end else begin
                        addr  <= addr + 1'b1;
                        state <= st_wr_setup;
                    end
                end
                st_reload: begin
                    addr  <= '0;
                    state <= st_rd_setup;
                end
                st_rd_setup: state <= st_rd_access;
                st_rd_access: if (pready) begin
                    if (mismatch) begin
                        err_run <= err_run + 1'b1;   // count bad word
                    end
                    if (addr == C_addr_last) begin
                        state <= st_verdict;
                    end else begin
                        addr  <= addr + 1'b1;
                        state <= st_rd_setup;
                    end
                end
                st_verdict: begin
                    err_words <= err_run;            // commit pass result
                    if (err_run != '0) begin
                        failcount <= failcount + 1'b1;
                    end else begin
                        passcount <= passcount + 1'b1;
                    end
                    pass_done <= 1'b1;
                    state     <= st_load;            // next pass right away
                end
                default: state <= st_load;
            endcase
        end
    end

    // address and direction frozen while the slave stalls
    a_ctrl_stable: assert property (
        @(posedge clk_gui) disable iff (timer_reset)
        (penable && !pready) |=> ($stable(paddr) && $stable(pwrite))
    );

    a_penable_psel: assert property (
        @(posedge clk_gui) disable iff (timer_reset)
        penable |-> psel
    );

endmodule

`default_nettype wire

//--- memtest_top.sv
`timescale 1ns/1ps
`default_nettype none

// soak tester top, tester + ram + elapsed time
module memtest_top import memtest_pkg::*; (
    input  wire        clk_gui,
    input  wire        timer_reset,
    input  wire word_t stuck_mask,   // fault injection into the ram
    output count_t     passcount,
    output count_t     failcount,
    output word_t      err_words,
    output logic       pass_done,
    output count_t     secs,
    output bcd4_t      mins,
    output logic [2:0] led
);

    ////////////////////
    // apb wires
    ////////////////////

    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    word_t pwdata;
    word_t prdata;
    logic  pready;

    mem_tester i_mem_tester (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .passcount   (passcount),
        .failcount   (failcount),
        .err_words   (err_words),
        .pass_done   (pass_done)
    );

    apb_sram i_apb_sram (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .stuck_mask  (stuck_mask),
        .prdata      (prdata),
        .pready      (pready)
    );

    elapsed_timer i_elapsed_timer (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .secs        (secs),
        .mins        (mins)
    );

    assign led = failcount[2:0];     // fail count is what matters on the board

endmodule

`default_nettype wire

//--- tb_memtest_checks.svh
`ifndef tb_memtest_checks_svh
`define tb_memtest_checks_svh

////////////////////
// run abort
////////////////////

task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
endtask

// failures with no value to compare, e.g. a lost pass_done
task automatic report_problem(input string what);
    $display("%s", what);
    stop_run();
endtask

////////////////////
// compares
////////////////////

// counters, secs, led widened
task automatic check_count(input string name, input count_t exp, input count_t act);
    if (act !== exp) begin
        $display("FAILED %s expected 0x%08h actual 0x%08h", name, exp, act);
        stop_run();
    end
endtask

// data words, err_words
task automatic check_words(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
        $display("FAILED %s expected 0x%04h actual 0x%04h", name, exp, act);
        stop_run();
    end
endtask

// minutes, four bcd digits
task automatic check_bcd(input string name, input bcd4_t exp, input bcd4_t act);
    if (act !== exp) begin
        $display("FAILED %s expected 0x%04h actual 0x%04h", name, exp, act);
        stop_run();
    end
endtask

`endif

//--- tb_memtest.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memtest import memtest_pkg::*; ();

    localparam int C_passes       = 30;    // well past ten scaled minutes
    localparam int C_pass_timeout = 1000;  // cycles per pass_done wait

    logic   clk_gui = 1'b0;
    logic   timer_reset;
    word_t  stuck_mask;
    count_t passcount;
    count_t failcount;
    word_t  err_words;
    logic   pass_done;
    count_t secs;
    bcd4_t  mins;
    logic [2:0] led;

    // model state
    count_t exp_pass;
    count_t exp_fail;
    count_t cyc;                           // non-reset edges seen
    word_t  cur_mask;                      // mask of the running pass

    `include "tb_memtest_checks.svh"

    always #20 clk_gui = ~clk_gui;         // 40 ns period

    memtest_top i_dut (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .stuck_mask  (stuck_mask),
        .passcount   (passcount),
        .failcount   (failcount),
        .err_words   (err_words),
        .pass_done   (pass_done),
        .secs        (secs),
        .mins        (mins),
        .led         (led)
    );

    always @(posedge clk_gui) begin
        if (timer_reset) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 1'b1;
        end
    end

    ////////////////////
    // reference model
    ////////////////////

    function automatic word_t lfsr_step(input word_t v);
        word_t n;
        n = v >> 1;                        // galois, shift right
        if (v[0]) begin
            n = n ^ C_lfsr_taps;
        end
        return n;
    endfunction

    // words where the pattern has a zero under a stuck bit
    function automatic int revealing_words(input int pass_k, input word_t mask);
        word_t v;
        int    n;
        v = (C_lfsr_seed ^ word_t'(pass_k)) | 16'h0001;
        n = 0;
        for (int a = 0; a < C_words; a++) begin
            if ((v & mask) != mask) begin
                n++;
            end
            v = lfsr_step(v);
        end
        return n;
    endfunction

    function automatic bcd4_t to_bcd4(input int unsigned value);
        bcd4_t       b;
        int unsigned rest;
        rest = value % 10000;              // counter wraps past 9999
        for (int i = 0; i < 4; i++) begin
            b[4*i +: 4] = 4'(rest % 10);
            rest = rest / 10;
        end
        return b;
    endfunction

    // zero half the time, else one or two stuck bits
    function automatic word_t pick_mask();
        word_t m;
        m = '0;
        if ($urandom % 2 == 1) begin
            m = word_t'(1) << ($urandom % 16);
            if ($urandom % 2 == 1) begin
                m = m | (word_t'(1) << ($urandom % 16));
            end
        end
        return m;
    endfunction

    ////////////////////
    // check helpers
    ////////////////////

    task automatic check_reset_values();
        check_count("passcount", '0, passcount);
        check_count("failcount", '0, failcount);
        check_words("err_words", '0, err_words);
        check_count("pass_done", '0, count_t'(pass_done));
        check_count("secs", '0, secs);
        check_bcd("mins", '0, mins);
        check_count("led", '0, count_t'(led));
    endtask

    // expected minutes are valid bcd, so a bad digit fails the compare
    task automatic check_time();
        count_t exp_secs;
        exp_secs = cyc / C_ticks_per_sec;
        check_count("secs", exp_secs, secs);
        check_bcd("mins", to_bcd4(exp_secs / C_secs_per_min), mins);
    endtask

    // led tracked every cycle until the pulse
    task automatic wait_pass_done();
        int waited;
        waited = 0;
        @(posedge clk_gui);
        while (!pass_done) begin
            check_count("led", count_t'(exp_fail[2:0]), count_t'(led));
            waited++;
            if (waited >= C_pass_timeout) begin
                report_problem("no pass_done within 1000 cycles, the pass never completed");
            end
            @(posedge clk_gui);
        end
    endtask

    ////////////////////
    // run
    ////////////////////

    initial begin
        word_t next_mask;
        int    exp_err;
        timer_reset = 1'b1;
        stuck_mask  = '0;
        cur_mask    = '0;
        exp_pass    = '0;
        exp_fail    = '0;
        void'($urandom(32'h479f_01d6));

        @(posedge clk_gui);                // first reset edge clears the dut
        repeat (2) begin
            @(posedge clk_gui);
            check_reset_values();
        end
        timer_reset <= 1'b0;               // three edges under reset
        @(posedge clk_gui);
        check_reset_values();
        check_time();

        for (int k = 0; k < C_passes; k++) begin
            wait_pass_done();
            exp_err = revealing_words(k, cur_mask);
            if (exp_err != 0) begin
                exp_fail = exp_fail + 1'b1;
            end else begin
                exp_pass = exp_pass + 1'b1;
            end
            check_words("err_words", word_t'(exp_err), err_words);
            check_count("passcount", exp_pass, passcount);
            check_count("failcount", exp_fail, failcount);
            check_count("led", count_t'(exp_fail[2:0]), count_t'(led));
            check_time();
            // next pass starts now, mask covers all of it
            next_mask = pick_mask();
            stuck_mask <= next_mask;
            cur_mask = next_mask;
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
memtest_pkg.sv
pattern_gen.sv
apb_sram.sv
elapsed_timer.sv
mem_tester.sv
memtest_top.sv
tb_memtest.sv

//--- Makefile
# verilator build and run of the memory soak tester testbench

.PHONY: all run clean

all: obj_dir/Vtb_memtest

# rebuilt only when a source, header or the file list changes
obj_dir/Vtb_memtest: verilog.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -j 0 --top-module tb_memtest -f verilog.f

# pass only if the pass line shows up in the simulator output
run: obj_dir/Vtb_memtest
	@out="$$(./obj_dir/Vtb_memtest 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
